/* stream_pkg.sv */
// Byte stream types
package stream_pkg;

    // **************************************************
    // Word and user field
    // **************************************************

    // Bytes per beat
    localparam int DATA_BYTES = 4;

    // Width of the per-packet word counter
    localparam int WORD_CNT_BITS = 16;

    typedef logic [8*DATA_BYTES-1:0] data_t;

    // Valid bytes in a beat, zero means a full word
    typedef logic [1:0] byte_cnt_t;

    // Error flag on top, byte count below
    typedef logic [2:0] user_t;

    // Forward half of a stream beat
    typedef struct packed {
        data_t data;
        user_t user;
        logic  last;
        logic  valid;
    } beat_t;

    // **************************************************
    // User field helpers
    // **************************************************

    function automatic logic get_error(user_t user);
        return user[2];
    endfunction

    // Byte count with a full word given as 4
    function automatic logic [2:0] get_bytes(user_t user);
        byte_cnt_t cnt;
        cnt = user[1:0];
        return (cnt == '0) ? 3'(DATA_BYTES) : {1'b0, cnt};
    endfunction

    // Count wraps to zero for a full word
    function automatic user_t make_user(logic error, logic [2:0] bytes);
        byte_cnt_t cnt;
        cnt = bytes[1:0];
        return {error, cnt};
    endfunction

endpackage

/* remove_pkg.sv */
// Byte removal control types
package remove_pkg;

    // Removal FSM states
    typedef enum logic [1:0] {
        PRE_REMOVE,
        REMOVING,
        POST_REMOVE,
        BONUS
    } remove_state_t;

    // Output data mux select
    typedef enum logic [2:0] {
        PASS_THRU,
        ONE_WORD,
        FIRST_SHIFT,
        PREFIRST_SHIFT,
        REM_SHIFT,
        BONUS_WORD
    } data_sel_t;

    // Where the current input beat sits relative to the range
    typedef struct packed {
        // Beat holds rem_start
        logic reached_start;
        // Beat holds rem_end
        logic reached_end;
        // Beat holds rem_end plus one word, or rem_end when wrapping
        logic reached_end_plus;
    } position_t;

endpackage

/* packet_position.sv */
// Packet word position tracker
module packet_position #(
    parameter int rem_start = 6,
    parameter int rem_end   = 9
) (
    input  logic                   s0,
    input  logic                   rst_n,
    input  logic                   in_fire,
    input  logic                   in_last,
    output remove_pkg::position_t  pos
);
    import stream_pkg::*;
    import remove_pkg::*;

    localparam int START_BYTE = rem_start % DATA_BYTES;
    localparam int END_BYTE   = rem_end % DATA_BYTES;
    localparam int START_WORD = rem_start / DATA_BYTES;
    localparam int END_WORD   = rem_end / DATA_BYTES;

    // Range bridges a word boundary without touching either edge
    localparam bit WRAP = (START_BYTE != 0) && (END_BYTE != DATA_BYTES-1) &&
                          (END_BYTE < START_BYTE);
    // Wrap case needs the end-plus word one beat early
    localparam int END_PLUS_WORD = WRAP ? END_WORD : END_WORD + 1;

    logic [WORD_CNT_BITS-1:0] word_cnt;

    // Index of the current input beat within its packet
    always_ff @(posedge s0 or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (in_fire) begin
            if (in_last)
                word_cnt <= '0;
            else
                word_cnt <= word_cnt + 1'b1;
        end
    end

    always_comb begin
        pos.reached_start    = (word_cnt == WORD_CNT_BITS'(START_WORD));
        pos.reached_end      = (word_cnt == WORD_CNT_BITS'(END_WORD));
        pos.reached_end_plus = (word_cnt == WORD_CNT_BITS'(END_PLUS_WORD));
    end

    // Packets longer than the counter would alias onto the range
    a_no_wrap: assert property (@(posedge s0) disable iff (!rst_n)
        in_fire && !in_last |=> word_cnt != '0)
        else $error("word counter wrapped inside a packet");

endmodule

/* word_shifter.sv */
// Static shift data path
module word_shifter #(
    parameter int rem_start = 6,
    parameter int rem_end   = 9
) (
    input  logic                       s0,
    input  logic                       rst_n,
    input  stream_pkg::data_t          in_data,
    input  logic                       in_fire,
    input  remove_pkg::remove_state_t  state,
    input  remove_pkg::data_sel_t      sel,
    input  logic                       first_last,
    output stream_pkg::data_t          out_data
);
    import stream_pkg::*;
    import remove_pkg::*;

    localparam int BYTES_REMOVED    = rem_end - rem_start + 1;
    localparam int START_BYTE       = rem_start % DATA_BYTES;
    localparam int END_BYTE         = rem_end % DATA_BYTES;
    localparam int FIRST_BYTE_AFTER = (END_BYTE + 1) % DATA_BYTES;
    localparam int BYTE_SHIFT       = BYTES_REMOVED % DATA_BYTES;

    localparam bit SINGLE       = BYTES_REMOVED <= DATA_BYTES;
    localparam bit START_AT_LSB = START_BYTE == 0;
    localparam bit END_AT_MSB   = END_BYTE == DATA_BYTES-1;
    localparam bit EXACT        = START_AT_LSB && END_AT_MSB;
    localparam bit MIDDLE       = END_BYTE >= START_BYTE;
    localparam bit MULTI_MIDDLE = !START_AT_LSB && !END_AT_MSB && MIDDLE && !SINGLE;

    data_t first_data;
    data_t last_data;
    data_t first_shift;
    data_t prefirst_shift;
    data_t rem_shift;
    data_t one_word;
    data_t bonus_word;

    // Low n bytes of a word
    function automatic data_t low_bytes(data_t d, int n);
        return d & ({$bits(data_t){1'b1}} >> ((DATA_BYTES - n) * 8));
    endfunction

    // Stack hi above the low n bytes of lo
    function automatic data_t join_bytes(data_t hi, data_t lo, int n);
        return (hi << (n * 8)) | low_bytes(lo, n);
    endfunction

    // Bytes past the removed range moved down to byte 0
    function automatic data_t end_part(data_t d);
        return d >> (FIRST_BYTE_AFTER * 8);
    endfunction

    function automatic data_t bs_part(data_t d);
        return d >> (BYTE_SHIFT * 8);
    endfunction

    // **************************************************
    // Word cache
    // **************************************************
    always_ff @(posedge s0 or negedge rst_n) begin
        if (!rst_n) begin
            first_data <= '0;
            last_data  <= '0;
        end else begin
            // Previous word feeds the shift in these cases
            if (in_fire && (MULTI_MIDDLE || START_AT_LSB) && state != BONUS)
                last_data <= in_data;
            if (in_fire && first_last)
                first_data <= in_data;
        end
    end

    // **************************************************
    // Shift combinations per range placement
    // **************************************************
    always_comb begin
        // Whole words removed
        first_shift    = in_data;
        prefirst_shift = in_data;
        rem_shift      = in_data;
        one_word       = in_data;
        bonus_word     = bs_part(in_data);
        if (EXACT) begin
            bonus_word = in_data;
        end else if (START_AT_LSB) begin
            // Leading bytes dropped and whole prior words already gone
            first_shift = join_bytes(in_data, bs_part(last_data), DATA_BYTES - BYTE_SHIFT);
            rem_shift   = first_shift;
            one_word    = end_part(in_data);
        end else if (END_AT_MSB) begin
            first_shift = join_bytes(in_data, first_data, START_BYTE);
            rem_shift   = join_bytes(in_data, bs_part(first_data), DATA_BYTES - BYTE_SHIFT);
        end else if (MIDDLE) begin
            // Kept head, then tail of the end word, then new data
            if (SINGLE) begin
                first_shift = join_bytes(join_bytes(in_data, end_part(first_data),
                                                    DATA_BYTES - FIRST_BYTE_AFTER),
                                         first_data, START_BYTE);
            end else begin
                prefirst_shift = join_bytes(end_part(in_data), first_data, START_BYTE);
                first_shift    = join_bytes(join_bytes(in_data, end_part(last_data),
                                                       DATA_BYTES - FIRST_BYTE_AFTER),
                                            first_data, START_BYTE);
            end
            rem_shift = join_bytes(in_data, bs_part(first_data), DATA_BYTES - BYTE_SHIFT);
            one_word  = join_bytes(end_part(in_data), in_data, START_BYTE);
        end else begin
            // Wrap across a word boundary
            first_shift = join_bytes(end_part(in_data), first_data, START_BYTE);
            rem_shift   = join_bytes(in_data, bs_part(first_data), DATA_BYTES - BYTE_SHIFT);
        end
        if (BYTE_SHIFT == 0)
            rem_shift = in_data;
    end

    always_comb begin
        case (sel)
            PASS_THRU:      out_data = in_data;
            ONE_WORD:       out_data = one_word;
            FIRST_SHIFT:    out_data = first_shift;
            PREFIRST_SHIFT: out_data = MULTI_MIDDLE ? prefirst_shift : first_shift;
            REM_SHIFT:      out_data = rem_shift;
            BONUS_WORD:     out_data = bonus_word;
            default:        out_data = in_data;
        endcase
    end

endmodule

/* remove_ctrl.sv */
// Byte removal controller
module remove_ctrl #(
    parameter int rem_start = 6,
    parameter int rem_end   = 9
) (
    input  logic                       s0,
    input  logic                       rst_n,
    input  stream_pkg::beat_t          in_beat,
    input  remove_pkg::position_t      pos,
    input  logic                       out_ready,
    output logic                       in_ready,
    output stream_pkg::user_t          out_user,
    output logic                       out_last,
    output logic                       out_valid,
    output remove_pkg::data_sel_t      sel,
    output remove_pkg::remove_state_t  state,
    output logic                       first_last
);
    import stream_pkg::*;
    import remove_pkg::*;

    localparam int BYTES_REMOVED    = rem_end - rem_start + 1;
    localparam int START_BYTE       = rem_start % DATA_BYTES;
    localparam int END_BYTE         = rem_end % DATA_BYTES;
    localparam int START_WORD       = rem_start / DATA_BYTES;
    localparam int END_WORD         = rem_end / DATA_BYTES;
    localparam int FIRST_BYTE_AFTER = (END_BYTE + 1) % DATA_BYTES;
    localparam int BYTE_SHIFT       = BYTES_REMOVED % DATA_BYTES;
    localparam int BYTE_CARRY       = DATA_BYTES - BYTE_SHIFT;

    localparam bit SINGLE       = BYTES_REMOVED <= DATA_BYTES;
    localparam bit START_AT_LSB = START_BYTE == 0;
    localparam bit END_AT_MSB   = END_BYTE == DATA_BYTES-1;
    localparam bit EXACT        = START_AT_LSB && END_AT_MSB;
    localparam bit MIDDLE       = END_BYTE >= START_BYTE;
    localparam bit MULTI_MIDDLE = !START_AT_LSB && !END_AT_MSB && MIDDLE && !SINGLE;
    localparam bit WRAP         = !START_AT_LSB && !END_AT_MSB && !MIDDLE;

    remove_state_t next_state;
    logic [2:0]    in_cnt;
    logic          err_acc;
    logic          err_now;
    logic          in_fire;
    logic          out_fire;

    assign in_cnt   = get_bytes(in_beat.user);
    assign err_now  = get_error(in_beat.user) || err_acc;
    assign in_fire  = in_beat.valid && in_ready;
    assign out_fire = out_valid && out_ready;

    // Capture the first word on start, on leaving removal, and outside removal
    assign first_last = pos.reached_start || next_state == POST_REMOVE ||
                        state != REMOVING;

    // **************************************************
    // Removal FSM
    // **************************************************
    always_comb begin
        next_state = state;
        sel        = PASS_THRU;
        out_user   = in_beat.user;
        out_last   = in_beat.last;
        out_valid  = in_beat.valid;
        in_ready   = out_ready;
        case (state)
            PRE_REMOVE: begin
                if (pos.reached_start && in_beat.last) begin
                    // Packet ends in the start word
                    sel = ONE_WORD;
                    if (in_cnt <= 3'(START_BYTE))
                        out_user = make_user(err_now, in_cnt);
                    else if (START_WORD != END_WORD || in_cnt <= 3'(END_BYTE))
                        out_user = make_user(1'b1, 3'(START_BYTE));
                    else
                        out_user = make_user(err_now, 3'(in_cnt - BYTES_REMOVED));
                    // Nothing left to terminate the packet with
                    if (START_AT_LSB)
                        out_user[2] = 1'b1;
                end else if (pos.reached_start) begin
                    out_valid = 1'b0;
                    if (in_beat.valid)
                        next_state = REMOVING;
                end
            end
            REMOVING: begin
                // Dropped beats are accepted freely
                sel       = FIRST_SHIFT;
                out_user  = make_user(1'b0, 3'(DATA_BYTES));
                out_last  = 1'b0;
                out_valid = 1'b0;
                in_ready  = 1'b1;
                if (in_beat.last && !pos.reached_end && !pos.reached_end_plus) begin
                    // Ended inside the range
                    out_user  = make_user(1'b1, 3'd0);
                    out_last  = 1'b1;
                    out_valid = in_beat.valid;
                    in_ready  = out_ready;
                    if (out_ready && in_beat.valid)
                        next_state = PRE_REMOVE;
                end else if (in_beat.last && pos.reached_end && !pos.reached_end_plus) begin
                    // Ends in the end word, kept bytes not shifted in yet
                    if (MULTI_MIDDLE)
                        sel = PREFIRST_SHIFT;
                    else if (START_AT_LSB)
                        sel = ONE_WORD;
                    out_last  = 1'b1;
                    out_valid = in_beat.valid;
                    in_ready  = out_ready;
                    if (in_cnt <= 3'(FIRST_BYTE_AFTER) || END_AT_MSB)
                        out_user = make_user(1'b1, 3'd0);
                    else if (MULTI_MIDDLE)
                        out_user = make_user(err_now, 3'(in_cnt + BYTE_CARRY));
                    else
                        out_user = make_user(err_now, 3'(in_cnt - FIRST_BYTE_AFTER));
                    if (EXACT)
                        out_user[2] = 1'b1;
                    if (out_ready && in_beat.valid)
                        next_state = PRE_REMOVE;
                end else if (in_beat.last && pos.reached_end_plus &&
                             in_cnt > 3'(BYTE_SHIFT) && BYTE_SHIFT != 0) begin
                    // Tail overflows, hold input for the bonus beat
                    out_valid = in_beat.valid;
                    in_ready  = 1'b0;
                    if (in_beat.valid && out_ready)
                        next_state = BONUS;
                end else if (in_beat.last && pos.reached_end_plus) begin
                    out_last  = 1'b1;
                    out_valid = in_beat.valid;
                    in_ready  = out_ready;
                    if (EXACT)
                        out_user = make_user(err_now, in_cnt);
                    else
                        out_user = make_user(err_now, 3'(in_cnt + BYTE_CARRY));
                    if (WRAP && in_cnt <= 3'(FIRST_BYTE_AFTER))
                        out_user = make_user(1'b1, 3'd0);
                    if (out_ready && in_beat.valid)
                        next_state = PRE_REMOVE;
                end else if (pos.reached_end_plus) begin
                    out_valid = in_beat.valid;
                    in_ready  = out_ready;
                    if (out_ready && in_beat.valid)
                        next_state = POST_REMOVE;
                end
            end
            POST_REMOVE: begin
                sel      = REM_SHIFT;
                out_user = make_user(1'b0, 3'(DATA_BYTES));
                out_last = 1'b0;
                if (in_beat.last && in_cnt > 3'(BYTE_SHIFT) && BYTE_SHIFT != 0) begin
                    in_ready = 1'b0;
                    if (in_beat.valid && out_ready)
                        next_state = BONUS;
                end else if (in_beat.last) begin
                    out_last = 1'b1;
                    out_user = make_user(err_now, 3'(in_cnt + BYTE_CARRY));
                    if (out_ready && in_beat.valid)
                        next_state = PRE_REMOVE;
                end
            end
            BONUS: begin
                // Final input beat presented again for its overflow bytes
                sel      = BONUS_WORD;
                out_user = make_user(err_now, 3'(in_cnt - BYTE_SHIFT));
                out_last = 1'b1;
                if (out_ready && in_beat.valid)
                    next_state = PRE_REMOVE;
            end
            default: next_state = PRE_REMOVE;
        endcase
    end

    always_ff @(posedge s0 or negedge rst_n) begin
        if (!rst_n)
            state <= PRE_REMOVE;
        else
            state <= next_state;
    end

    // Error accumulates per packet, held until the bonus beat leaves
    always_ff @(posedge s0 or negedge rst_n) begin
        if (!rst_n)
            err_acc <= 1'b0;
        else if (out_fire && out_last && state == BONUS)
            err_acc <= 1'b0;
        else if (in_fire && in_beat.last && next_state != BONUS)
            err_acc <= 1'b0;
        else if (in_fire)
            err_acc <= err_now;
    end

    a_hold_off: assert property (@(posedge s0) disable iff (!rst_n)
        !in_ready |-> !out_ready ||
            (in_beat.valid && in_beat.last && state inside {REMOVING, POST_REMOVE}))
        else $error("input held off outside the bonus condition");

    a_no_removed_out: assert property (@(posedge s0) disable iff (!rst_n)
        state == REMOVING && !in_beat.last && !pos.reached_end_plus |-> !out_valid)
        else $error("output valid for a removed beat");

endmodule

/* byte_remover.sv */
// Byte range remover top
module byte_remover #(
    parameter int rem_start = 6,
    parameter int rem_end   = 9
) (
    input  logic               s0,
    input  logic               rst_n,
    input  stream_pkg::beat_t  in_beat,
    output logic               in_ready,
    output stream_pkg::beat_t  out_beat,
    input  logic               out_ready
);
    import remove_pkg::*;

    position_t     pos;
    remove_state_t state;
    data_sel_t     sel;
    logic          first_last;
    logic          in_fire;

    // Input transfer strobe
    assign in_fire = in_beat.valid && in_ready;

    packet_position #(
        .rem_start (rem_start),
        .rem_end   (rem_end)
    ) packet_position_i (
        .s0      (s0),
        .rst_n   (rst_n),
        .in_fire (in_fire),
        .in_last (in_beat.last),
        .pos     (pos)
    );

    remove_ctrl #(
        .rem_start (rem_start),
        .rem_end   (rem_end)
    ) remove_ctrl_i (
        .s0         (s0),
        .rst_n      (rst_n),
        .in_beat    (in_beat),
        .pos        (pos),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_user   (out_beat.user),
        .out_last   (out_beat.last),
        .out_valid  (out_beat.valid),
        .sel        (sel),
        .state      (state),
        .first_last (first_last)
    );

    word_shifter #(
        .rem_start (rem_start),
        .rem_end   (rem_end)
    ) word_shifter_i (
        .s0         (s0),
        .rst_n      (rst_n),
        .in_data    (in_beat.data),
        .in_fire    (in_fire),
        .state      (state),
        .sel        (sel),
        .first_last (first_last),
        .out_data   (out_beat.data)
    );

endmodule

/* byte_remover_checker.sv */
// Byte remover output checker
module byte_remover_checker (
    input  logic               s0,
    input  logic               rst_n,
    input  stream_pkg::beat_t  out_beat,
    input  logic               out_ready,
    output int                 err_cnt,
    output int                 n_checked,
    output int                 n_expected
);
    import stream_pkg::*;

    localparam int MAX_REC = 64;

    logic [31:0] golden [0:4*MAX_REC-1];

    // Expected output beats in arrival order
    data_t exp_data [0:MAX_REC-1];
    user_t exp_user [0:MAX_REC-1];
    logic  exp_last [0:MAX_REC-1];

    // Only bytes inside the beat's count are compared
    function automatic data_t valid_byte_mask(user_t user);
        int n;
        n = (user[1:0] == 2'd0) ? 4 : int'(user[1:0]);
        return 32'hffff_ffff >> (8 * (4 - n));
    endfunction

    // **************************************************
    // Expected list from the golden file
    // **************************************************
    initial begin
        int r;
        err_cnt    = 0;
        n_checked  = 0;
        n_expected = 0;
        for (r = 0; r < 4*MAX_REC; r++)
            golden[r] = '0;
        $readmemh("remove_golden.txt", golden);
        for (r = 0; r < MAX_REC; r++) begin
            if (golden[4*r] == 32'd2) begin
                exp_last[n_expected] = golden[4*r+1][0];
                exp_user[n_expected] = golden[4*r+2][2:0];
                exp_data[n_expected] = golden[4*r+3];
                n_expected++;
            end
        end
    end

    // **************************************************
    // Compare each output transfer
    // **************************************************
    // Sampled mid cycle where the combinational output is settled
    always @(negedge s0) begin : compare
        data_t mask;
        if (rst_n && out_beat.valid && out_ready) begin
            if (n_checked >= n_expected) begin
                err_cnt++;
                $display("output beat %0d arrived after the last expected beat", n_checked);
            end else begin
                mask = valid_byte_mask(exp_user[n_checked]);
                if ((out_beat.data & mask) !== (exp_data[n_checked] & mask)) begin
                    err_cnt++;
                    $display("mismatch out_beat.data beat %0d: got %h, expected %h",
                             n_checked, out_beat.data & mask, exp_data[n_checked] & mask);
                end
                if (out_beat.user !== exp_user[n_checked]) begin
                    err_cnt++;
                    $display("mismatch out_beat.user beat %0d: got %h, expected %h",
                             n_checked, out_beat.user, exp_user[n_checked]);
                end
                if (out_beat.last !== exp_last[n_checked]) begin
                    err_cnt++;
                    $display("mismatch out_beat.last beat %0d: got %h, expected %h",
                             n_checked, out_beat.last, exp_last[n_checked]);
                end
            end
            n_checked++;
        end
    end

endmodule

/* tb_byte_remover.sv */
// Byte remover testbench
module tb_byte_remover;
    import stream_pkg::*;

    localparam int MAX_REC   = 64;
    localparam int PERIOD    = 8;
    localparam int DRIVE_DLY = 1;

    logic  s0;
    logic  rst_n;
    beat_t in_beat;
    logic  in_ready;
    beat_t out_beat;
    logic  out_ready;

    // Four hex columns per golden line
    logic [31:0] golden [0:4*MAX_REC-1];

    int seed = 95027;
    int n_in;
    int limit;
    int cycles;
    int err_cnt;
    int n_checked;
    int n_expected;

    // Wrap case, range crosses the word 1 to word 2 boundary
    byte_remover #(
        .rem_start (6),
        .rem_end   (9)
    ) byte_remover_i (
        .s0        (s0),
        .rst_n     (rst_n),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    byte_remover_checker checker_i (
        .s0         (s0),
        .rst_n      (rst_n),
        .out_beat   (out_beat),
        .out_ready  (out_ready),
        .err_cnt    (err_cnt),
        .n_checked  (n_checked),
        .n_expected (n_expected)
    );

    initial begin
        s0 = 1'b0;
        forever #(PERIOD/2) s0 = ~s0;
    end

    // Sink stalls, driven one step after the source
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge s0);
            #(DRIVE_DLY + 1);
            out_ready = ($random(seed) % 4) != 0;
        end
    end

    // **************************************************
    // Source side
    // **************************************************
    task automatic send_beat(input data_t data, input user_t user, input logic last);
        logic taken;
        // Random idle cycles ahead of the beat
        while (($random(seed) % 3) == 0) begin
            @(posedge s0);
            #(DRIVE_DLY);
        end
        in_beat.data  = data;
        in_beat.user  = user;
        in_beat.last  = last;
        in_beat.valid = 1'b1;
        taken = 1'b0;
        // in_ready is settled mid cycle
        while (!taken) begin
            @(negedge s0);
            taken = in_ready;
            @(posedge s0);
            #(DRIVE_DLY);
        end
        in_beat.valid = 1'b0;
    endtask

    task end_run(input logic timed_out);
        if (n_checked != n_expected)
            $display("only %0d of %0d expected output beats arrived", n_checked, n_expected);
        if (n_expected == 0)
            $display("golden file holds no expected output beats");
        $display("errors: %0d, output beats checked: %0d", err_cnt, n_checked);
        if (!timed_out && err_cnt == 0 && n_expected > 0 && n_checked == n_expected)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    initial begin
        int r;
        in_beat = '0;
        rst_n   = 1'b0;
        n_in    = 0;
        limit   = 0;
        for (r = 0; r < 4*MAX_REC; r++)
            golden[r] = '0;
        $readmemh("remove_golden.txt", golden);
        for (r = 0; r < MAX_REC; r++) begin
            if (golden[4*r] == 32'd1)
                n_in++;
        end
        limit = 40 * n_in;
        repeat (3) @(posedge s0);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        for (r = 0; r < MAX_REC; r++) begin
            if (golden[4*r] == 32'd1)
                send_beat(golden[4*r+3], golden[4*r+2][2:0], golden[4*r+1][0]);
        end
        // Drain the output, then a few idle cycles to catch stray beats
        while (n_checked < n_expected)
            @(posedge s0);
        repeat (4) @(posedge s0);
        end_run(1'b0);
    end

    // Run limit scales with the stimulus length
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge s0);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d output beats seen",
                 cycles, n_checked, n_expected);
        end_run(1'b1);
    end

endmodule

/* remove_golden.txt */
// Each line holds kind, last, user and data of one beat
// Kind 1 is an input beat and kind 2 an expected output beat
// User is the error flag above the 2-bit byte count, count 0 means 4 bytes
// Packet of 16 bytes shortened to 12
1 0 0 13121110
1 0 0 17161514
1 0 0 1B1A1918
1 1 0 1F1E1D1C
2 0 0 13121110
2 0 0 1B1A1514
2 1 0 1F1E1D1C
// Packet of 18 bytes with an input error on its third beat
1 0 0 43424140
1 0 0 47464544
1 0 4 4B4A4948
1 0 0 4F4E4D4C
1 1 2 00005150
2 0 0 43424140
2 0 0 4B4A4544
2 0 0 4F4E4D4C
2 1 6 00005150
// Packet of 5 bytes ending ahead of the range
1 0 0 73727170
1 1 1 00000074
2 0 0 73727170
2 1 1 00000074
// Packet of 8 bytes ending inside the range
1 0 0 83828180
1 1 0 87868584
2 0 0 83828180
2 1 6 87868584
// Packet of 11 bytes with a 3-byte tail
1 0 0 A3A2A1A0
1 0 0 A7A6A5A4
1 1 3 00AAA9A8
2 0 0 A3A2A1A0
2 1 3 00AAA5A4

/* tb.f */
stream_pkg.sv
remove_pkg.sv
packet_position.sv
word_shifter.sv
remove_ctrl.sv
byte_remover.sv
byte_remover_checker.sv
tb_byte_remover.sv
